// File: design/kvw_apb_regs.sv
// APB without wait states; misaligned or unmapped accesses error, read-only writes are dropped
module kvw_apb_regs (
  input  logic               clk,
  input  logic               reset_n,
  // APB
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  kvw_pkg::paddr_t    paddr_i,
  input  kvw_pkg::word_t     pwdata_i,
  output kvw_pkg::word_t     prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  // Key loader
  output logic               load_o,
  output kvw_pkg::kv_entry_t entry_o,
  input  logic               loader_ready_i,
  input  logic               key_valid_i,
  input  logic               kv_err_i,
  // Mask generator
  output logic               seed_wr_o,
  output kvw_pkg::word_idx_t seed_idx_o,
  output kvw_pkg::word_t     seed_word_o,
  input  logic               seeded_i,
  // Whitening core
  output logic               start_o,
  output kvw_pkg::word_t     data_o [kvw_pkg::KEY_WORDS],
  input  logic               busy_i,
  input  logic               share_wr_i,
  input  kvw_pkg::word_idx_t share_idx_i,
  input  kvw_pkg::word_t     share0_i,
  input  kvw_pkg::word_t     share1_i,
  input  logic               done_i,
  // Level interrupts
  output logic               notif_o,
  output logic               error_o
);

  import kvw_pkg::*;

  logic      acc;
  logic      wr;
  logic      aligned;
  word_idx_t idx;
  logic      hit_ctrl;
  logic      hit_status;
  logic      hit_kv;
  logic      hit_seed;
  logic      hit_data;
  logic      hit_sh0;
  logic      hit_sh1;
  logic      mapped;
  logic      kv_wr_ok;
  word_t     status;
  word_t     share0_q [KEY_WORDS];
  word_t     share1_q [KEY_WORDS];

  // ========================================
  // Decode
  // ========================================

  // Transfer completes in the access phase
  assign acc     = psel_i & penable_i;
  assign wr      = acc & pwrite_i;
  assign aligned = (paddr_i[1:0] == 2'b00);
  // Word slot inside a four-word bank
  assign idx     = paddr_i[3:2];

  assign hit_ctrl   = (paddr_i == REG_CTRL);
  assign hit_status = (paddr_i == REG_STATUS);
  assign hit_kv     = (paddr_i == REG_KV_CTRL);
  assign hit_seed   = aligned & (paddr_i[7:4] == REG_SEED[7:4]);
  assign hit_data   = aligned & (paddr_i[7:4] == REG_DATA[7:4]);
  assign hit_sh0    = aligned & (paddr_i[7:4] == REG_SHARE0[7:4]);
  assign hit_sh1    = aligned & (paddr_i[7:4] == REG_SHARE1[7:4]);
  assign mapped     = hit_ctrl | hit_status | hit_kv | hit_seed | hit_data | hit_sh0 | hit_sh1;

  assign pready_o  = 1'b1;
  assign pslverr_o = acc & ~mapped;

  // ========================================
  // Commands
  // ========================================

  // Vault control frozen during a run or a fetch
  assign kv_wr_ok = wr & hit_kv & ~busy_i & loader_ready_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      entry_o <= '0;
      load_o  <= 1'b0;
    end else begin
      if (kv_wr_ok) begin
        entry_o <= pwdata_i[2:0];
      end
      // One cycle late so the loader sees the new entry
      load_o <= kv_wr_ok & pwdata_i[KV_READ_EN];
    end
  end

  // Start needs a clean key and an idle core
  assign start_o = wr & hit_ctrl & pwdata_i[CTRL_START] & key_valid_i & ~busy_i;

  // Seed words go straight to the generator
  assign seed_wr_o   = wr & hit_seed;
  assign seed_idx_o  = idx;
  assign seed_word_o = pwdata_i;

  // ========================================
  // Data and share banks
  // ========================================

  // Block words locked while the core reads them
  always_ff @(posedge clk) begin
    if (wr && hit_data && !busy_i) begin
      data_o[idx] <= pwdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (share_wr_i) begin
      share0_q[share_idx_i] <= share0_i;
      share1_q[share_idx_i] <= share1_i;
    end
  end

  // ========================================
  // Readback
  // ========================================
  always_comb begin
    status                = '0;
    status[STS_BUSY]      = busy_i;
    status[STS_KEY_VALID] = key_valid_i;
    status[STS_SEEDED]    = seeded_i;
    status[STS_KV_ERR]    = kv_err_i;
    status[STS_DONE]      = done_i;
  end

  // CTRL and SEED read as zero
  always_comb begin
    prdata_o = '0;
    if (hit_status) begin
      prdata_o = status;
    end else if (hit_kv) begin
      prdata_o = {29'd0, entry_o};
    end else if (hit_data) begin
      prdata_o = data_o[idx];
    end else if (hit_sh0) begin
      prdata_o = share0_q[idx];
    end else if (hit_sh1) begin
      prdata_o = share1_q[idx];
    end
  end

  // Interrupt levels follow the status bits
  assign notif_o = done_i;
  assign error_o = kv_err_i;

endmodule

// File: design/kvw_key_loader.sv
// Vault must answer in the same cycle; one error on any word discards the whole key
module kvw_key_loader (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                load_i,
  input  kvw_pkg::kv_entry_t  entry_i,
  // Vault read port
  output logic                kv_rd_req_o,
  output kvw_pkg::kv_entry_t  kv_rd_entry_o,
  output kvw_pkg::kv_offset_t kv_rd_offset_o,
  input  kvw_pkg::word_t      kv_rd_data_i,
  input  logic                kv_rd_err_i,
  // Status and key
  output logic                ready_o,
  output logic                key_valid_o,
  output logic                kv_err_o,
  output kvw_pkg::word_t      key_o [kvw_pkg::KEY_WORDS]
);

  import kvw_pkg::*;

  loader_state_e state_q;
  kv_offset_t    off_q;
  kv_entry_t     entry_q;
  kv_err_e       err_q;
  word_t         swz;
  logic          last;

  // Vault is big-endian against the engine
  assign swz  = {kv_rd_data_i[7:0], kv_rd_data_i[15:8],
                 kv_rd_data_i[23:16], kv_rd_data_i[31:24]};
  assign last = (off_q == kv_offset_t'(KEY_WORDS - 1));

  // ========================================
  // Fetch FSM
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= LD_IDLE;
      off_q   <= '0;
      entry_q <= '0;
      err_q   <= KV_OK;
    end else begin
      case (state_q)
        LD_IDLE, LD_DONE: begin
          // New request drops the old key and error at once
          if (load_i) begin
            state_q <= LD_READ;
            off_q   <= '0;
            entry_q <= entry_i;
            err_q   <= KV_BUSY;
          end
        end
        LD_READ: begin
          off_q <= off_q + 1'b1;
          if (kv_rd_err_i) begin
            state_q <= LD_IDLE;
            err_q   <= KV_READ_FAIL;
          end else if (last) begin
            state_q <= LD_DONE;
            err_q   <= KV_OK;
          end
        end
        default: state_q <= LD_IDLE;
      endcase
    end
  end

  // Key word per read, wiped on a new request or a failed read
  always_ff @(posedge clk) begin
    if (load_i && ready_o) begin
      for (int i = 0; i < KEY_WORDS; i++) begin
        key_o[i] <= '0;
      end
    end else if (kv_rd_req_o && kv_rd_err_i) begin
      for (int i = 0; i < KEY_WORDS; i++) begin
        key_o[i] <= '0;
      end
    end else if (kv_rd_req_o) begin
      key_o[off_q] <= swz;
    end
  end

  assign kv_rd_req_o    = (state_q == LD_READ);
  assign kv_rd_entry_o  = entry_q;
  assign kv_rd_offset_o = off_q;
  assign ready_o        = (state_q != LD_READ);
  // Valid only after four clean words
  assign key_valid_o    = (state_q == LD_DONE);
  assign kv_err_o       = (err_q == KV_READ_FAIL);

endmodule

// File: design/kvw_mask_prng.sv
// Masks repeat after reset until firmware seeds; an all-zero seed locks the output at zero
module kvw_mask_prng (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               seed_wr_i,
  input  kvw_pkg::word_idx_t seed_idx_i,
  input  kvw_pkg::word_t     seed_word_i,
  input  logic               step_i,
  output kvw_pkg::word_t     mask_o,
  output logic               seeded_o
);

  import kvw_pkg::*;

  logic [SEED_WORDS-1:0] seed_vld_q;
  logic [SEED_WORDS-1:0] seed_hit;
  logic                  reseed;
  word_t                 seed_q [SEED_WORDS];
  // x, y, z, w from low to high
  word_t                 st_q [SEED_WORDS];
  word_t                 t;
  word_t                 w_next;

  // ========================================
  // Seed tracking
  // ========================================
  assign seed_hit = seed_wr_i ? (SEED_WORDS'(1) << seed_idx_i) : '0;
  // Full set written since the last reseed
  assign reseed   = &seed_vld_q;

  // A write landing on the reseed cycle is not counted
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      seed_vld_q <= '0;
    end else begin
      seed_vld_q <= reseed ? '0 : (seed_vld_q | seed_hit);
    end
  end

  always_ff @(posedge clk) begin
    if (seed_wr_i) begin
      seed_q[seed_idx_i] <= seed_word_i;
    end
  end

  // ========================================
  // xorshift128
  // ========================================
  assign t      = st_q[0] ^ (st_q[0] << 11);
  assign w_next = st_q[3] ^ (st_q[3] >> 19) ^ t ^ (t >> 8);

  // Reseed wins over a step in the same cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < SEED_WORDS; i++) begin
        st_q[i] <= PRNG_RESET_STATE[32*i +: 32];
      end
      seeded_o <= 1'b0;
    end else if (reseed) begin
      for (int i = 0; i < SEED_WORDS; i++) begin
        st_q[i] <= seed_q[i];
      end
      seeded_o <= 1'b1;
    end else if (step_i) begin
      st_q[0] <= st_q[1];
      st_q[1] <= st_q[2];
      st_q[2] <= st_q[3];
      st_q[3] <= w_next;
    end
  end

  // Newest word
  assign mask_o = st_q[3];

endmodule

// File: design/kvw_pkg.sv
// Word-aligned APB map only; an all-zero seed gives all-zero masks; no real cipher datapath
package kvw_pkg;

  // ========================================
  // Widths
  // ========================================

  // Data, seed, mask and key word
  typedef logic [31:0] word_t;
  // APB byte address
  typedef logic [7:0]  paddr_t;
  // Vault entry and word within an entry
  typedef logic [2:0]  kv_entry_t;
  typedef logic [1:0]  kv_offset_t;
  // Word slot in a key, block or seed set
  typedef logic [1:0]  word_idx_t;

  localparam int unsigned KEY_WORDS  = 4;
  localparam int unsigned SEED_WORDS = 4;

  // xorshift128 start state, x in the low word, w in the high word
  localparam logic [127:0] PRNG_RESET_STATE = 128'h05491333_1F123BB5_159A55E5_075BCD15;

  // ========================================
  // Register map
  // ========================================
  localparam paddr_t REG_CTRL    = 8'h00;
  localparam paddr_t REG_STATUS  = 8'h04;
  localparam paddr_t REG_KV_CTRL = 8'h08;
  // Four-word banks, base of each
  localparam paddr_t REG_SEED    = 8'h10;
  localparam paddr_t REG_DATA    = 8'h20;
  localparam paddr_t REG_SHARE0  = 8'h30;
  localparam paddr_t REG_SHARE1  = 8'h40;

  // Field positions
  localparam int unsigned CTRL_START    = 0;
  localparam int unsigned KV_READ_EN    = 8;
  localparam int unsigned STS_BUSY      = 0;
  localparam int unsigned STS_KEY_VALID = 1;
  localparam int unsigned STS_SEEDED    = 2;
  localparam int unsigned STS_KV_ERR    = 3;
  localparam int unsigned STS_DONE      = 4;

  // ========================================
  // Codes and states
  // ========================================

  // Vault read result, busy while a fetch is in flight
  typedef enum logic [1:0] {
    KV_OK        = 2'd0,
    KV_READ_FAIL = 2'd1,
    KV_BUSY      = 2'd2
  } kv_err_e;

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_READ,
    LD_DONE
  } loader_state_e;

  typedef enum logic {
    CORE_IDLE,
    CORE_RUN
  } core_state_e;

endpackage

// File: design/kvw_top.sv
// Vault port is combinational; start to done readable takes 5 cycles
module kvw_top (
  input  logic                clk,
  input  logic                reset_n,
  // APB
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  kvw_pkg::paddr_t     paddr_i,
  input  kvw_pkg::word_t      pwdata_i,
  output kvw_pkg::word_t      prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // Vault read port
  output logic                kv_rd_req_o,
  output kvw_pkg::kv_entry_t  kv_rd_entry_o,
  output kvw_pkg::kv_offset_t kv_rd_offset_o,
  input  kvw_pkg::word_t      kv_rd_data_i,
  input  logic                kv_rd_err_i,
  // Status and interrupts
  output logic                busy_o,
  output logic                notif_o,
  output logic                error_o
);

  import kvw_pkg::*;

  // Regs and loader
  logic      load;
  kv_entry_t entry;
  logic      loader_ready;
  logic      key_valid;
  logic      kv_err;
  word_t     key [KEY_WORDS];
  // Regs and generator
  logic      seed_wr;
  word_idx_t seed_idx;
  word_t     seed_word;
  logic      seeded;
  // Regs, core and generator
  logic      start;
  word_t     data [KEY_WORDS];
  logic      share_wr;
  word_idx_t share_idx;
  word_t     share0;
  word_t     share1;
  logic      done;
  logic      step;
  word_t     mask;

  kvw_apb_regs u_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .load_o         (load),
    .entry_o        (entry),
    .loader_ready_i (loader_ready),
    .key_valid_i    (key_valid),
    .kv_err_i       (kv_err),
    .seed_wr_o      (seed_wr),
    .seed_idx_o     (seed_idx),
    .seed_word_o    (seed_word),
    .seeded_i       (seeded),
    .start_o        (start),
    .data_o         (data),
    .busy_i         (busy_o),
    .share_wr_i     (share_wr),
    .share_idx_i    (share_idx),
    .share0_i       (share0),
    .share1_i       (share1),
    .done_i         (done),
    .notif_o        (notif_o),
    .error_o        (error_o)
  );

  kvw_key_loader u_loader (
    .clk            (clk),
    .reset_n        (reset_n),
    .load_i         (load),
    .entry_i        (entry),
    .kv_rd_req_o    (kv_rd_req_o),
    .kv_rd_entry_o  (kv_rd_entry_o),
    .kv_rd_offset_o (kv_rd_offset_o),
    .kv_rd_data_i   (kv_rd_data_i),
    .kv_rd_err_i    (kv_rd_err_i),
    .ready_o        (loader_ready),
    .key_valid_o    (key_valid),
    .kv_err_o       (kv_err),
    .key_o          (key)
  );

  kvw_mask_prng u_prng (
    .clk         (clk),
    .reset_n     (reset_n),
    .seed_wr_i   (seed_wr),
    .seed_idx_i  (seed_idx),
    .seed_word_i (seed_word),
    .step_i      (step),
    .mask_o      (mask),
    .seeded_o    (seeded)
  );

  kvw_whiten_core u_core (
    .clk         (clk),
    .reset_n     (reset_n),
    .start_i     (start),
    .data_i      (data),
    .key_i       (key),
    .mask_i      (mask),
    .step_o      (step),
    .busy_o      (busy_o),
    .share_wr_o  (share_wr),
    .share_idx_o (share_idx),
    .share0_o    (share0),
    .share1_o    (share1),
    .done_o      (done)
  );

endmodule

// File: design/kvw_whiten_core.sv
// Data and key must stay stable for the whole run; the register block enforces this
module kvw_whiten_core (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               start_i,
  input  kvw_pkg::word_t     data_i [kvw_pkg::KEY_WORDS],
  input  kvw_pkg::word_t     key_i [kvw_pkg::KEY_WORDS],
  input  kvw_pkg::word_t     mask_i,
  output logic               step_o,
  output logic               busy_o,
  output logic               share_wr_o,
  output kvw_pkg::word_idx_t share_idx_o,
  output kvw_pkg::word_t     share0_o,
  output kvw_pkg::word_t     share1_o,
  output logic               done_o
);

  import kvw_pkg::*;

  core_state_e state_q;
  word_idx_t   idx_q;
  logic        last;

  assign last = (idx_q == word_idx_t'(KEY_WORDS - 1));

  // ========================================
  // Block FSM
  // ========================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= CORE_IDLE;
      idx_q   <= '0;
      done_o  <= 1'b0;
    end else begin
      case (state_q)
        CORE_IDLE: begin
          // Accepted start clears the previous done
          if (start_i) begin
            state_q <= CORE_RUN;
            idx_q   <= '0;
            done_o  <= 1'b0;
          end
        end
        CORE_RUN: begin
          idx_q <= idx_q + 1'b1;
          // Done with the last share pair
          if (last) begin
            state_q <= CORE_IDLE;
            done_o  <= 1'b1;
          end
        end
        default: state_q <= CORE_IDLE;
      endcase
    end
  end

  // ========================================
  // Share pair
  // ========================================
  assign busy_o      = (state_q == CORE_RUN);
  assign share_wr_o  = busy_o;
  assign share_idx_o = idx_q;
  // XOR of the two shares gives data XOR key
  assign share0_o    = data_i[idx_q] ^ key_i[idx_q] ^ mask_i;
  assign share1_o    = mask_i;
  // Fresh mask for every word
  assign step_o      = busy_o;

endmodule

// File: dv/kvw_asserts.sv
// Assumes a vault that flags an error on every word of a locked entry, so aborts end after one read
module kvw_asserts (
  input logic clk,
  input logic reset_n,
  input logic pready_i,
  input logic kv_rd_req_i,
  input logic kv_rd_err_i,
  input logic busy_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failures seen so far
  int unsigned fail_count = 0;

  // No wait states
  pready_high: assert property (@(posedge clk) disable iff (!reset_n) pready_i)
    else begin
      $error("pready dropped low");
      fail_count++;
    end

  // Clean load reads four offsets back to back
  kv_req_len: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(kv_rd_req_i) && !kv_rd_err_i |-> kv_rd_req_i[*4] ##1 !kv_rd_req_i)
    else begin
      $error("vault read request not four cycles long");
      fail_count++;
    end

  // Error aborts the fetch
  kv_req_abort: assert property (@(posedge clk) disable iff (!reset_n)
      kv_rd_req_i && kv_rd_err_i |=> !kv_rd_req_i)
    else begin
      $error("vault read request kept after error");
      fail_count++;
    end

  // One word per cycle
  busy_len: assert property (@(posedge clk) disable iff (!reset_n)
      $rose(busy_i) |-> busy_i[*4] ##1 !busy_i)
    else begin
      $error("busy not four cycles long");
      fail_count++;
    end

endmodule

bind kvw_top kvw_asserts u_asserts (
  .clk         (clk),
  .reset_n     (reset_n),
  .pready_i    (pready_o),
  .kv_rd_req_i (kv_rd_req_o),
  .kv_rd_err_i (kv_rd_err_i),
  .busy_i      (busy_o)
);

// File: dv/kvw_tb.sv
// Vault model answers in the same cycle and errors on every word of a locked entry; LCG seed 22
module kvw_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import kvw_pkg::*;

  localparam int unsigned POLL_LIMIT = 20;

  logic       clk;
  logic       reset_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  paddr_t     paddr;
  word_t      pwdata;
  word_t      prdata;
  logic       pready;
  logic       pslverr;
  logic       kv_rd_req;
  kv_entry_t  kv_rd_entry;
  kv_offset_t kv_rd_offset;
  word_t      kv_rd_data;
  logic       kv_rd_err;
  logic       busy;
  logic       notif;
  logic       error;

  // Reference state
  word_t      rng_state;
  word_t      vault_mem [32];
  logic [7:0] locked;
  kv_entry_t  cur_entry;
  word_t      exp_key [KEY_WORDS];
  // x, y, z, w of the mask generator copy
  word_t      model_st [4];

  // ========================================
  // Vault model and DUT
  // ========================================
  assign kv_rd_data = vault_mem[{kv_rd_entry, kv_rd_offset}];
  assign kv_rd_err  = kv_rd_req & locked[kv_rd_entry];

  kvw_top dut_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr),
    .kv_rd_req_o    (kv_rd_req),
    .kv_rd_entry_o  (kv_rd_entry),
    .kv_rd_offset_o (kv_rd_offset),
    .kv_rd_data_i   (kv_rd_data),
    .kv_rd_err_i    (kv_rd_err),
    .busy_o         (busy),
    .notif_o        (notif),
    .error_o        (error)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic word_t next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Vault words arrive big-endian
  function automatic word_t byte_swap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // One xorshift128 step, shifts 11, 8 and 19
  task automatic model_step();
    word_t t;
    t = model_st[0] ^ (model_st[0] << 11);
    model_st[0] = model_st[1];
    model_st[1] = model_st[2];
    model_st[2] = model_st[3];
    model_st[3] = model_st[3] ^ (model_st[3] >> 19) ^ t ^ (t >> 8);
  endtask

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    $display("CHECK FAILED: %s expected 0x%08h actual 0x%08h", name, exp, act);
    $display("TEST RESULT: FAIL");
    $fatal(1, "mismatch in %s", name);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout on %s", what);
  endtask

  // APB write, entered and left on a falling edge
  task automatic apb_write(input paddr_t addr, input word_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    #5;
    check_word("write pslverr", 32'd0, {31'd0, pslverr});
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Read data sampled mid access phase
  task automatic apb_read(input paddr_t addr, output word_t data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #5;
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Poll STATUS until any masked bit is set
  task automatic poll_status(input word_t mask, input string what, output word_t sts);
    logic err;
    apb_read(REG_STATUS, sts, err);
    for (int n = 1; n < POLL_LIMIT && (sts & mask) == 0; n++) begin
      apb_read(REG_STATUS, sts, err);
    end
    if ((sts & mask) == 0) begin
      report_timeout(what);
    end
  endtask

  task automatic load_key(input kv_entry_t entry, output word_t sts);
    cur_entry = entry;
    apb_write(REG_KV_CTRL, (32'd1 << KV_READ_EN) | 32'(entry));
    poll_status((32'd1 << STS_KEY_VALID) | (32'd1 << STS_KV_ERR), "key load", sts);
    for (int i = 0; i < KEY_WORDS; i++) begin
      exp_key[i] = byte_swap(vault_mem[{entry, 2'(i)}]);
    end
  endtask

  // Block run, optionally with DATA and KV_CTRL writes that land mid run
  task automatic run_block(input string name, input logic disturb);
    word_t data [KEY_WORDS];
    word_t sts;
    word_t s0;
    word_t s1;
    word_t rd;
    logic  err;
    for (int i = 0; i < KEY_WORDS; i++) begin
      data[i] = next_rand();
      apb_write(REG_DATA + paddr_t'(4 * i), data[i]);
    end
    apb_write(REG_CTRL, 32'd1 << CTRL_START);
    // Accepted start drops the previous done
    check_word({name, " notif at start"}, 32'd0, {31'd0, notif});
    if (disturb) begin
      apb_write(REG_DATA, ~data[0]);
      apb_write(REG_KV_CTRL, (32'd1 << KV_READ_EN) | 32'(cur_entry + 3'd1));
    end
    poll_status(32'd1 << STS_DONE, {name, " done"}, sts);
    check_word({name, " notif at done"}, 32'd1, {31'd0, notif});
    check_word({name, " key_valid"}, 32'd1, {31'd0, sts[STS_KEY_VALID]});
    // Mask for word i is the newest state word, then one step
    for (int i = 0; i < KEY_WORDS; i++) begin
      apb_read(REG_SHARE0 + paddr_t'(4 * i), s0, err);
      apb_read(REG_SHARE1 + paddr_t'(4 * i), s1, err);
      check_word({name, " share1"}, model_st[3], s1);
      check_word({name, " share xor"}, data[i] ^ exp_key[i], s0 ^ s1);
      model_step();
    end
    if (disturb) begin
      apb_read(REG_DATA, rd, err);
      check_word({name, " data kept"}, data[0], rd);
      apb_read(REG_KV_CTRL, rd, err);
      check_word({name, " entry kept"}, 32'(cur_entry), rd);
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    word_t     rnd;
    word_t     sts;
    word_t     rd;
    logic      err;
    kv_entry_t open_entry;
    kv_entry_t locked_entry;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    reset_n   = 1'b0;
    cur_entry = '0;
    rng_state = 32'd22;

    // Random vault with at least one locked and one open entry
    for (int a = 0; a < 32; a++) begin
      vault_mem[a] = next_rand();
    end
    rnd    = next_rand();
    locked = rnd[15:8];
    if (locked == 8'h00) begin
      locked[5] = 1'b1;
    end
    if (locked == 8'hFF) begin
      locked[2] = 1'b0;
    end
    rnd        = next_rand();
    open_entry = rnd[2:0];
    while (locked[open_entry]) begin
      open_entry = open_entry + 3'd1;
    end
    locked_entry = rnd[5:3];
    while (!locked[locked_entry]) begin
      locked_entry = locked_entry + 3'd1;
    end
    for (int i = 0; i < 4; i++) begin
      model_st[i] = PRNG_RESET_STATE[32*i +: 32];
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // Reset values
    apb_read(REG_STATUS, sts, err);
    check_word("reset status", 32'd0, sts);
    check_word("status pslverr", 32'd0, {31'd0, err});
    check_word("reset busy", 32'd0, {31'd0, busy});
    check_word("reset notif", 32'd0, {31'd0, notif});
    check_word("reset error", 32'd0, {31'd0, error});
    apb_read(8'h50, rd, err);
    check_word("unmapped pslverr", 32'd1, {31'd0, err});

    // Locked entry, start must be dropped
    load_key(locked_entry, sts);
    check_word("locked kv_err", 32'd1, {31'd0, sts[STS_KV_ERR]});
    check_word("locked key_valid", 32'd0, {31'd0, sts[STS_KEY_VALID]});
    check_word("locked error_o", 32'd1, {31'd0, error});
    apb_write(REG_CTRL, 32'd1 << CTRL_START);
    for (int i = 0; i < 6; i++) begin
      apb_read(REG_STATUS, sts, err);
      check_word("dropped start busy", 32'd0, {31'd0, sts[STS_BUSY]});
      check_word("dropped start done", 32'd0, {31'd0, sts[STS_DONE]});
    end
    check_word("dropped start notif", 32'd0, {31'd0, notif});

    // Open entry, masks still from the reset state
    load_key(open_entry, sts);
    check_word("open kv_err", 32'd0, {31'd0, sts[STS_KV_ERR]});
    check_word("open key_valid", 32'd1, {31'd0, sts[STS_KEY_VALID]});
    check_word("open error_o", 32'd0, {31'd0, error});
    run_block("unseeded block", 1'b0);

    // Full seed set
    for (int i = 0; i < SEED_WORDS; i++) begin
      model_st[i] = next_rand();
      apb_write(REG_SEED + paddr_t'(4 * i), model_st[i]);
    end
    poll_status(32'd1 << STS_SEEDED, "seeded", sts);
    run_block("seeded block 0", 1'b0);
    run_block("seeded block 1", 1'b0);
    // Three words only, the state keeps running
    for (int i = 0; i < SEED_WORDS - 1; i++) begin
      apb_write(REG_SEED + paddr_t'(4 * i), next_rand());
    end
    run_block("partial seed block", 1'b0);

    // Writes during a run, then a clean follow-up start
    run_block("busy writes", 1'b1);
    run_block("next start", 1'b0);

    if (dut_i.u_asserts.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Bound protocol assertions failed %0d times", dut_i.u_asserts.fail_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "protocol assertion failures");
    end
  end

endmodule

// File: vlog.f
design/kvw_pkg.sv
design/kvw_apb_regs.sv
design/kvw_key_loader.sv
design/kvw_mask_prng.sv
design/kvw_whiten_core.sv
design/kvw_top.sv
dv/kvw_asserts.sv
dv/kvw_tb.sv
